// File: source/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// cache geometry
`define CACHE_WAYS  2
`define CACHE_SETS  256
`define CACHE_BANKS 4

// address fields, byte offset within a line at the bottom
`define TAG_W       20
`define INDEX_W     8
`define OFFSET_W    4

`define WORD_W      32

// victim select lfsr start value
`define LFSR_SEED   4'b1111

`endif

// File: source/cache_pkg.sv
`include "cache_params.svh"

package cache_pkg;

    typedef logic [`TAG_W-1:0]                 tag_t;
    typedef logic [`INDEX_W-1:0]               index_t;
    typedef logic [$clog2(`CACHE_BANKS)-1:0]   bank_t;
    typedef logic [`WORD_W-1:0]                word_t;
    typedef logic [`WORD_W/8-1:0]              strb_t;
    typedef logic [`CACHE_BANKS*`WORD_W-1:0]   line_t;

    // one tag ram entry
    typedef struct packed {
        tag_t tag;
        logic valid;
    } tagv_t;

    // strobed bytes come from new_word, the rest from old_word
    function automatic word_t merge_bytes(word_t old_word, word_t new_word, strb_t strb);
        word_t merged;
        merged = old_word;
        for (int i = 0; i < `WORD_W / 8; i++)
        begin
            if (strb[i])
            begin
                merged[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return merged;
    endfunction

endpackage

// File: source/way_ram.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module way_ram #(
    parameter type entry_t = logic,
    parameter int  DEPTH   = `CACHE_SETS
) (
    input  logic              clk,
    input  logic              we,
    input  cache_pkg::index_t addr,
    input  entry_t            wdata,
    output entry_t            rdata
);

    entry_t mem [DEPTH];

    // power-up contents, so every line starts out invalid
    initial
    begin
        mem = '{default: '0};
    end

    // read returns the old entry on a same-address write
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

// File: source/cache_store.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_store (
    input  logic                    clk,
    input  logic                    rst,
    input  cache_pkg::index_t       ram_index,
    input  cache_pkg::tag_t         lookup_tag,
    input  cache_pkg::bank_t        lookup_bank,
    input  logic                    line_way,
    input  logic [`CACHE_BANKS-1:0] bank_we,
    input  cache_pkg::word_t        write_word,
    input  logic                    tag_we,
    input  logic                    dirty_value,
    input  logic                    mark_dirty,
    output logic                    hit,
    output logic                    hit_way,
    output cache_pkg::word_t        hit_word,
    output logic                    victim_way,
    output logic                    victim_dirty,
    output cache_pkg::tag_t         victim_tag,
    output cache_pkg::line_t        victim_line
);

    import cache_pkg::*;

    tagv_t                  tagv_rd [`CACHE_WAYS];
    word_t                  word_rd [`CACHE_WAYS][`CACHE_BANKS];
    logic [`CACHE_WAYS-1:0] way_hit;
    logic [`CACHE_SETS-1:0] dirty [`CACHE_WAYS];
    index_t                 index_q;
    logic [3:0]             lfsr;

    for (genvar w = 0; w < `CACHE_WAYS; w++)
    begin : g_way
        way_ram #(.entry_t(tagv_t), .DEPTH(`CACHE_SETS)) tagv_ram (
            .clk   (clk),
            .we    (tag_we && (line_way == w)),
            .addr  (ram_index),
            .wdata ('{tag: lookup_tag, valid: 1'b1}),
            .rdata (tagv_rd[w])
        );

        for (genvar b = 0; b < `CACHE_BANKS; b++)
        begin : g_bank
            way_ram #(.entry_t(word_t), .DEPTH(`CACHE_SETS)) data_ram (
                .clk   (clk),
                .we    (bank_we[b] && (line_way == w)),
                .addr  (ram_index),
                .wdata (write_word),
                .rdata (word_rd[w][b])
            );
        end
    end

    // ram outputs belong to last cycle's index
    always_ff @(posedge clk)
    begin
        index_q <= ram_index;
    end

    always_comb
    begin
        for (int i = 0; i < `CACHE_WAYS; i++)
        begin
            way_hit[i] = tagv_rd[i].valid && (tagv_rd[i].tag == lookup_tag);
        end
    end

    assign hit      = |way_hit;
    assign hit_way  = way_hit[1];
    assign hit_word = word_rd[hit_way][lookup_bank];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            dirty <= '{default: '0};
        end
        else if (tag_we)
        begin
            dirty[line_way][ram_index] <= dirty_value;
        end
        else if (mark_dirty)
        begin
            dirty[line_way][ram_index] <= 1'b1;
        end
    end

    // x^4 + x^3 + 1, runs every cycle
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            lfsr <= `LFSR_SEED;
        end
        else
        begin
            lfsr <= {lfsr[2:0], lfsr[3] ^ lfsr[2]};
        end
    end

    assign victim_way   = lfsr[0];
    assign victim_tag   = tagv_rd[victim_way].tag;
    assign victim_dirty = tagv_rd[victim_way].valid && dirty[victim_way][index_q];

    always_comb
    begin
        for (int b = 0; b < `CACHE_BANKS; b++)
        begin
            victim_line[b*`WORD_W +: `WORD_W] = word_rd[victim_way][b];
        end
    end

endmodule

// File: source/cache_ctrl.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    input  logic                    req_write,
    input  logic [31:0]             req_addr,
    input  cache_pkg::strb_t        req_wstrb,
    input  cache_pkg::word_t        req_wdata,
    output logic                    req_ready,
    output logic                    resp_valid,
    output cache_pkg::word_t        resp_rdata,
    output logic                    mem_wr_valid,
    output logic [31:0]             mem_wr_addr,
    output cache_pkg::line_t        mem_wr_data,
    input  logic                    mem_wr_ready,
    output logic                    mem_rd_valid,
    output logic [31:0]             mem_rd_addr,
    input  logic                    mem_rd_ready,
    input  logic                    mem_ret_valid,
    input  logic                    mem_ret_last,
    input  cache_pkg::word_t        mem_ret_data,
    output cache_pkg::index_t       ram_index,
    output cache_pkg::tag_t         lookup_tag,
    output cache_pkg::bank_t        lookup_bank,
    output logic                    line_way,
    output logic [`CACHE_BANKS-1:0] bank_we,
    output cache_pkg::word_t        write_word,
    output logic                    tag_we,
    output logic                    dirty_value,
    output logic                    mark_dirty,
    input  logic                    hit,
    input  logic                    hit_way,
    input  cache_pkg::word_t        hit_word,
    input  logic                    victim_way,
    input  logic                    victim_dirty,
    input  cache_pkg::tag_t         victim_tag,
    input  cache_pkg::line_t        victim_line
);

    import cache_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_writeback,
        st_refill_req,
        st_refill
    } state_t;

    state_t state, state_nxt;
    logic   accept;

    // request buffer
    logic   rb_write;
    tag_t   rb_tag;
    index_t rb_index;
    bank_t  rb_bank;
    strb_t  rb_wstrb;
    word_t  rb_wdata;

    // miss buffer
    logic   mb_way;
    tag_t   mb_tag;
    line_t  mb_line;
    bank_t  beat;

    assign accept = req_valid && req_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= st_idle;
        end
        else
        begin
            state <= state_nxt;
        end
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            st_idle:
            begin
                if (req_valid)
                begin
                    state_nxt = st_lookup;
                end
            end
            st_lookup:
            begin
                if (hit)
                begin
                    state_nxt = st_idle;
                end
                else if (victim_dirty)
                begin
                    state_nxt = st_writeback;
                end
                else
                begin
                    state_nxt = st_refill_req;
                end
            end
            st_writeback:
            begin
                if (mem_wr_ready)
                begin
                    state_nxt = st_refill_req;
                end
            end
            st_refill_req:
            begin
                if (mem_rd_ready)
                begin
                    state_nxt = st_refill;
                end
            end
            st_refill:
            begin
                if (mem_ret_valid && mem_ret_last)
                begin
                    state_nxt = st_idle;
                end
            end
            default:
            begin
                state_nxt = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            rb_write <= req_write;
            rb_tag   <= req_addr[`OFFSET_W+`INDEX_W +: `TAG_W];
            rb_index <= req_addr[`OFFSET_W +: `INDEX_W];
            rb_bank  <= req_addr[`OFFSET_W-1:2];
            rb_wstrb <= req_wstrb;
            rb_wdata <= req_wdata;
        end
    end

    // victim is captured in the lookup cycle, the store keeps rolling the lfsr
    always_ff @(posedge clk)
    begin
        if (state == st_lookup && !hit)
        begin
            mb_way  <= victim_way;
            mb_tag  <= victim_tag;
            mb_line <= victim_line;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            beat <= '0;
        end
        else if (state == st_refill && mem_ret_valid)
        begin
            beat <= beat + 1'b1;
        end
    end

    assign ram_index   = (state == st_idle) ? req_addr[`OFFSET_W +: `INDEX_W] : rb_index;
    assign lookup_tag  = rb_tag;
    assign lookup_bank = rb_bank;

    always_comb
    begin
        line_way   = mb_way;
        bank_we    = '0;
        write_word = mem_ret_data;
        if (state == st_lookup)
        begin
            line_way   = hit_way;
            write_word = merge_bytes(hit_word, rb_wdata, rb_wstrb);
            if (hit && rb_write)
            begin
                bank_we[rb_bank] = 1'b1;
            end
        end
        else if (state == st_refill)
        begin
            // store data lands on top of the refilled word
            if (rb_write && beat == rb_bank)
            begin
                write_word = merge_bytes(mem_ret_data, rb_wdata, rb_wstrb);
            end
            if (mem_ret_valid)
            begin
                bank_we[beat] = 1'b1;
            end
        end
    end

    assign tag_we      = (state == st_refill) && mem_ret_valid && mem_ret_last;
    assign dirty_value = rb_write;
    assign mark_dirty  = (state == st_lookup) && hit && rb_write;

    assign req_ready  = (state == st_idle);
    assign resp_valid = ((state == st_lookup) && hit)
                        || ((state == st_refill) && mem_ret_valid && beat == rb_bank);
    assign resp_rdata = (state == st_refill) ? mem_ret_data : hit_word;

    assign mem_wr_valid = (state == st_writeback);
    assign mem_wr_addr  = {mb_tag, rb_index, {`OFFSET_W{1'b0}}};
    assign mem_wr_data  = mb_line;
    assign mem_rd_valid = (state == st_refill_req);
    assign mem_rd_addr  = {rb_tag, rb_index, {`OFFSET_W{1'b0}}};

endmodule

// File: source/cache_top.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    input  logic              req_write,
    input  logic [31:0]       req_addr,
    input  cache_pkg::strb_t  req_wstrb,
    input  cache_pkg::word_t  req_wdata,
    output logic              req_ready,
    output logic              resp_valid,
    output cache_pkg::word_t  resp_rdata,
    output logic              mem_wr_valid,
    output logic [31:0]       mem_wr_addr,
    output cache_pkg::line_t  mem_wr_data,
    input  logic              mem_wr_ready,
    output logic              mem_rd_valid,
    output logic [31:0]       mem_rd_addr,
    input  logic              mem_rd_ready,
    input  logic              mem_ret_valid,
    input  logic              mem_ret_last,
    input  cache_pkg::word_t  mem_ret_data
);

    import cache_pkg::*;

    // controller to store
    index_t                  ram_index;
    tag_t                    lookup_tag;
    bank_t                   lookup_bank;
    logic                    line_way;
    logic [`CACHE_BANKS-1:0] bank_we;
    word_t                   write_word;
    logic                    tag_we;
    logic                    dirty_value;
    logic                    mark_dirty;

    // store to controller
    logic                    hit;
    logic                    hit_way;
    word_t                   hit_word;
    logic                    victim_way;
    logic                    victim_dirty;
    tag_t                    victim_tag;
    line_t                   victim_line;

    cache_ctrl cache_ctrl_inst (.*);

    cache_store cache_store_inst (.*);

endmodule

// File: dv/cache_checker.sv
`timescale 1ns/1ps

module cache_checker (
    input logic             clk,
    input logic             rst,
    input logic             req_valid,
    input logic             req_write,
    input logic [31:0]      req_addr,
    input cache_pkg::strb_t req_wstrb,
    input cache_pkg::word_t req_wdata,
    input logic             req_ready,
    input logic             resp_valid,
    input cache_pkg::word_t resp_rdata,
    input logic             mem_wr_valid,
    input logic [31:0]      mem_wr_addr,
    input cache_pkg::line_t mem_wr_data,
    input logic             mem_wr_ready,
    input logic             mem_rd_valid,
    input logic [31:0]      mem_rd_addr,
    input logic             mem_rd_ready,
    input cache_pkg::word_t exp_rdata
);

    import cache_pkg::*;

    // shadow holds only the words that were written
    word_t       shadow [logic [29:0]];
    // lines written since their last write-back
    bit          written_lines [logic [27:0]];

    int          cycle = 0;
    int          shadow_errors = 0;
    int          case_errors = 0;
    int          protocol_errors = 0;
    int          accept_count = 0;
    int          wb_count = 0;

    bit          seen_request = 1'b0;
    bit          pending = 1'b0;
    bit          pend_write;
    bit          pend_refill;
    int          accept_cycle;
    logic [31:0] pend_addr;
    word_t       pend_shadow;
    word_t       pend_case;

    // the line of the previous request is still resident
    bit          expect_hit = 1'b0;
    logic [27:0] last_line;

    function automatic word_t shadow_word(logic [31:0] addr);
        if (shadow.exists(addr[31:2]))
        begin
            return shadow[addr[31:2]];
        end
        return {addr[31:2], 2'b00} ^ 32'h5a5a0000;
    endfunction

    task automatic reset_idle_state();
        if (req_ready !== 1'b1 || resp_valid !== 1'b0
            || mem_wr_valid !== 1'b0 || mem_rd_valid !== 1'b0)
        begin
            protocol_errors++;
            $display("cache not idle at %0t before the first request", $time);
        end
    endtask

    task automatic compare_response();
        if (!pending)
        begin
            protocol_errors++;
            $display("response at %0t without an outstanding request", $time);
            return;
        end
        if (expect_hit && pend_refill)
        begin
            protocol_errors++;
            $display("request to 0x%08h missed at %0t although its line was just accessed",
                     pend_addr, $time);
        end
        // no refill means it was a hit
        if (!pend_refill && cycle != accept_cycle + 1)
        begin
            protocol_errors++;
            $display("hit response at %0t came %0d cycles after acceptance instead of 1",
                     $time, cycle - accept_cycle);
        end
        if (!pend_write && resp_rdata !== pend_shadow)
        begin
            shadow_errors++;
            $display("FAILED %0t: read 0x%08h returned 0x%08h, shadow memory has 0x%08h",
                     $time, pend_addr, resp_rdata, pend_shadow);
        end
        if (!pend_write && resp_rdata !== pend_case)
        begin
            case_errors++;
            $display("FAILED %0t: read 0x%08h returned 0x%08h, cases file expects 0x%08h",
                     $time, pend_addr, resp_rdata, pend_case);
        end
        pending = 1'b0;
    endtask

    task automatic match_refill_address();
        pend_refill = 1'b1;
        if (!pending || mem_rd_addr !== {pend_addr[31:4], 4'b0000})
        begin
            protocol_errors++;
            $display("refill request at %0t for 0x%08h does not belong to the current request",
                     $time, mem_rd_addr);
        end
    endtask

    task automatic compare_write_back();
        logic [31:0] word_addr;
        word_t       expect_word;
        wb_count++;
        if (!written_lines.exists(mem_wr_addr[31:4]))
        begin
            protocol_errors++;
            $display("write-back at %0t of line 0x%08h that holds no written data",
                     $time, mem_wr_addr);
        end
        else
        begin
            written_lines.delete(mem_wr_addr[31:4]);
        end
        for (int b = 0; b < 4; b++)
        begin
            word_addr = {mem_wr_addr[31:4], 4'b0000} + 32'(4 * b);
            expect_word = shadow_word(word_addr);
            if (mem_wr_data[b*32 +: 32] !== expect_word)
            begin
                shadow_errors++;
                $display("FAILED %0t: write-back word 0x%08h is 0x%08h, shadow memory has 0x%08h",
                         $time, word_addr, mem_wr_data[b*32 +: 32], expect_word);
            end
        end
    endtask

    task automatic record_request();
        if (pending)
        begin
            protocol_errors++;
            $display("request accepted at %0t while another was outstanding", $time);
        end
        expect_hit = seen_request && (req_addr[31:4] == last_line);
        last_line = req_addr[31:4];
        seen_request = 1'b1;
        pending = 1'b1;
        pend_write = req_write;
        pend_refill = 1'b0;
        pend_addr = req_addr;
        pend_case = exp_rdata;
        pend_shadow = shadow_word(req_addr);
        accept_cycle = cycle;
        accept_count++;
        if (req_write)
        begin
            shadow[req_addr[31:2]] = merge_bytes(pend_shadow, req_wdata, req_wstrb);
            written_lines[req_addr[31:4]] = 1'b1;
        end
    endtask

    // request inputs and cache outputs are both settled at the falling edge
    always @(negedge clk)
    begin
        if (!rst)
        begin
            cycle++;
            if (!seen_request)
            begin
                reset_idle_state();
            end
            if (resp_valid)
            begin
                compare_response();
            end
            if (mem_rd_valid && mem_rd_ready)
            begin
                match_refill_address();
            end
            if (mem_wr_valid && mem_wr_ready)
            begin
                compare_write_back();
            end
            if (req_valid && req_ready)
            begin
                record_request();
            end
        end
    end

    task automatic finish_report(input int expected_requests, input int driver_errors,
                                 output int total);
        if (pending)
        begin
            protocol_errors++;
            $display("request to 0x%08h never received a response", pend_addr);
        end
        if (accept_count != expected_requests)
        begin
            protocol_errors++;
            $display("%0d requests accepted but %0d were issued", accept_count,
                     expected_requests);
        end
        if (wb_count == 0)
        begin
            protocol_errors++;
            $display("no write-back seen although written lines had to be evicted");
        end
        total = shadow_errors + case_errors + protocol_errors + driver_errors;
        $display("%0d requests, %0d write-backs: %0d shadow, %0d case, %0d protocol, %0d driver errors",
                 accept_count, wb_count, shadow_errors, case_errors, protocol_errors,
                 driver_errors);
    endtask

endmodule

// File: dv/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;

    import cache_pkg::*;

    localparam int    WAIT_LIMIT = 200;
    localparam string CASES_FILE = "dv/cache_cases.txt";

    logic        clk;
    logic        rst;
    logic        req_valid;
    logic        req_write;
    logic [31:0] req_addr;
    strb_t       req_wstrb;
    word_t       req_wdata;
    logic        req_ready;
    logic        resp_valid;
    word_t       resp_rdata;
    logic        mem_wr_valid;
    logic [31:0] mem_wr_addr;
    line_t       mem_wr_data;
    logic        mem_wr_ready;
    logic        mem_rd_valid;
    logic [31:0] mem_rd_addr;
    logic        mem_rd_ready;
    logic        mem_ret_valid;
    logic        mem_ret_last;
    word_t       mem_ret_data;
    word_t       exp_rdata;

    // requests from the cases file
    logic        case_write [$];
    logic [31:0] case_addr [$];
    strb_t       case_strb [$];
    word_t       case_wdata [$];
    word_t       case_expect [$];

    // only lines that were written back, the rest follow the initial pattern
    line_t       mem_lines [logic [27:0]];

    int          timeouts = 0;
    int          setup_errors = 0;
    int          total_errors;

    cache_top cache_top_inst (.*);

    cache_checker cache_checker_inst (.*);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #50;
            clk = ~clk;
        end
    end

    function automatic line_t read_line(logic [31:0] addr);
        line_t       words;
        logic [31:0] word_addr;
        if (mem_lines.exists(addr[31:4]))
        begin
            return mem_lines[addr[31:4]];
        end
        for (int b = 0; b < 4; b++)
        begin
            word_addr = {addr[31:4], 4'b0000} + 32'(4 * b);
            words[b*32 +: 32] = word_addr ^ 32'h5a5a0000;
        end
        return words;
    endfunction

    // handshakes are sampled mid-cycle, outputs change just after the edge
    initial
    begin : memory_model
        bit          wr_fire;
        bit          rd_fire;
        logic [31:0] wr_addr_q;
        line_t       wr_data_q;
        logic [31:0] rd_addr_q;
        line_t       ret_line;
        int          ret_beat;
        bit          ret_active;
        ret_active = 1'b0;
        ret_beat = 0;
        mem_wr_ready = 1'b0;
        mem_rd_ready = 1'b0;
        mem_ret_valid = 1'b0;
        mem_ret_last = 1'b0;
        mem_ret_data = '0;
        void'($urandom(32'h2e79c42e));
        forever
        begin
            @(negedge clk);
            wr_fire = mem_wr_valid && mem_wr_ready;
            rd_fire = mem_rd_valid && mem_rd_ready;
            wr_addr_q = mem_wr_addr;
            wr_data_q = mem_wr_data;
            rd_addr_q = mem_rd_addr;
            @(posedge clk);
            #1;
            if (wr_fire)
            begin
                mem_lines[wr_addr_q[31:4]] = wr_data_q;
            end
            if (rd_fire)
            begin
                ret_line = read_line(rd_addr_q);
                ret_beat = 0;
                ret_active = 1'b1;
            end
            mem_ret_valid = 1'b0;
            mem_ret_last = 1'b0;
            // beats come with random gaps
            if (ret_active && ($urandom % 4) != 0)
            begin
                mem_ret_valid = 1'b1;
                mem_ret_data = ret_line[ret_beat*32 +: 32];
                mem_ret_last = (ret_beat == 3);
                ret_active = (ret_beat != 3);
                ret_beat++;
            end
            mem_wr_ready = ($urandom % 2) == 1;
            mem_rd_ready = ($urandom % 2) == 1;
        end
    end

    task automatic load_cases();
        int          fd;
        int          fields;
        string       text;
        logic [31:0] f_write;
        logic [31:0] f_addr;
        logic [31:0] f_strb;
        logic [31:0] f_data;
        logic [31:0] f_expect;
        fd = $fopen(CASES_FILE, "r");
        if (fd == 0)
        begin
            $display("could not open %s", CASES_FILE);
            setup_errors++;
            return;
        end
        while ($feof(fd) == 0)
        begin
            text = "";
            void'($fgets(text, fd));
            fields = $sscanf(text, "%h %h %h %h %h", f_write, f_addr, f_strb, f_data, f_expect);
            if (fields == 5)
            begin
                case_write.push_back(f_write[0]);
                case_addr.push_back(f_addr);
                case_strb.push_back(f_strb[3:0]);
                case_wdata.push_back(f_data);
                case_expect.push_back(f_expect);
            end
        end
        $fclose(fd);
        if (case_write.size() == 0)
        begin
            $display("no requests found in %s", CASES_FILE);
            setup_errors++;
        end
    endtask

    task automatic wait_ready(output bit ok);
        int waited;
        waited = 0;
        ok = 1'b1;
        @(negedge clk);
        while (req_ready !== 1'b1)
        begin
            waited++;
            if (waited > WAIT_LIMIT)
            begin
                $display("timeout at %0t: req_ready stayed low for %0d cycles", $time, WAIT_LIMIT);
                ok = 1'b0;
                return;
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_response(output bit ok);
        int waited;
        waited = 0;
        ok = 1'b1;
        @(negedge clk);
        while (resp_valid !== 1'b1)
        begin
            waited++;
            if (waited > WAIT_LIMIT)
            begin
                $display("timeout at %0t: no response within %0d cycles", $time, WAIT_LIMIT);
                ok = 1'b0;
                return;
            end
            @(negedge clk);
        end
    endtask

    task automatic run_case(input int idx);
        bit ok;
        @(posedge clk);
        #1;
        req_valid = 1'b1;
        req_write = case_write[idx];
        req_addr = case_addr[idx];
        req_wstrb = case_strb[idx];
        req_wdata = case_wdata[idx];
        exp_rdata = case_expect[idx];
        wait_ready(ok);
        if (!ok)
        begin
            timeouts++;
            return;
        end
        // accepting edge
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        wait_response(ok);
        if (!ok)
        begin
            timeouts++;
        end
    endtask

    initial
    begin
        bit ok;
        rst = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr = '0;
        req_wstrb = '0;
        req_wdata = '0;
        exp_rdata = '0;
        load_cases();
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (3) @(posedge clk);
        for (int i = 0; i < case_write.size() && timeouts == 0; i++)
        begin
            run_case(i);
        end
        if (timeouts == 0)
        begin
            wait_ready(ok);
            if (!ok)
            begin
                timeouts++;
            end
        end
        @(negedge clk);
        cache_checker_inst.finish_report(case_write.size(), timeouts + setup_errors,
                                         total_errors);
        if (total_errors == 0)
        begin
            $display("Done: no errors");
        end
        else
        begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: dv/cache_cases.txt
// columns: write flag, address, byte strobes, write data, expected read data
// all hex; the expected value of a write is ignored
0 00001000 0 00000000 5a5a1000
0 00001000 0 00000000 5a5a1000
0 0000100c 0 00000000 5a5a100c
0 00002348 0 00000000 5a5a2348
1 00001004 3 deadbeef 00000000
0 00001004 0 00000000 5a5abeef
1 00001004 8 11223344 00000000
0 00001004 0 00000000 115abeef
1 00003128 c cafef00d 00000000
0 00003128 0 00000000 cafe3128
0 00003120 0 00000000 5a5a3120
1 00004444 f 01234567 00000000
0 00004444 0 00000000 01234567
0 00100200 0 00000000 5a4a0200
0 00200200 0 00000000 5a7a0200
0 00300200 0 00000000 5a6a0200
0 00400200 0 00000000 5a1a0200
0 00100204 0 00000000 5a4a0204
1 00010804 f aaaa0001 00000000
1 00020808 f bbbb0002 00000000
1 0003080c f cccc0003 00000000
0 00010804 0 00000000 aaaa0001
0 00020808 0 00000000 bbbb0002
0 0003080c 0 00000000 cccc0003
0 00010800 0 00000000 5a5b0800
1 00010800 1 000000ff 00000000
0 00040800 0 00000000 5a5e0800
0 00050800 0 00000000 5a5f0800
0 00010800 0 00000000 5a5b08ff
0 00010804 0 00000000 aaaa0001
0 00002348 0 00000000 5a5a2348
0 00001004 0 00000000 115abeef

// File: filelist.f
+incdir+source
source/cache_pkg.sv
source/way_ram.sv
source/cache_store.sv
source/cache_ctrl.sv
source/cache_top.sv
dv/cache_checker.sv
dv/cache_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build cache_tb with Verilator, run it and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module cache_tb -f filelist.f -o cache_sim
	./obj_dir/cache_sim > $(LOG) 2>&1; cat $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
